// ==== project.f ====
common/lsu_pkg.sv
hw/lsu/lsu_phase_ctrl.sv
hw/lsu/lsu_store_align.sv
hw/lsu/lsu_load_extract.sv
hw/lsu_top.sv
bench/tb_clock_gen.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

// ==== Makefile ====
# Verilator build for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/lsu_tb.sv ====
/* Testbench top for the load/store unit.
   Applies a request table, models an AHB-Lite slave with wait states. */

`timescale 1ns/1ns

module lsu_tb;

   localparam int NUM = 35;
   localparam lsu_pkg::mem_size_e SZ_B = lsu_pkg::SIZE_BYTE;
   localparam lsu_pkg::mem_size_e SZ_H = lsu_pkg::SIZE_HALF;
   localparam lsu_pkg::mem_size_e SZ_W = lsu_pkg::SIZE_WORD;

   typedef struct {
      lsu_pkg::lsu_req_t req;
      int                waits;
      lsu_pkg::data_t    exp;
   } entry_t;

   logic               clk;
   logic               rst_n;
   lsu_pkg::lsu_req_t  req;
   lsu_pkg::data_t     hrdatad;
   logic               hreadyd;
   lsu_pkg::addr_t     haddrd;
   lsu_pkg::mem_size_e hsized;
   logic               hwrited;
   logic               htransd;
   lsu_pkg::data_t     hwdatad;
   lsu_pkg::wb_t       wb;
   logic               stall;
   lsu_pkg::data_t     exp_data;
   int                 cur_idx;
   int                 done_count;
   int                 error_count;

   entry_t         tbl[NUM];
   int             n_entries;
   lsu_pkg::data_t mem[16];

   // Slave snapshot from the falling edge
   logic               acc_s;
   lsu_pkg::addr_t     addr_s;
   lsu_pkg::mem_size_e size_s;
   logic               write_s;
   lsu_pkg::data_t     wdata_s;
   int                 idx_s;

   // Slave data phase
   logic               dp_valid;
   logic               dp_write;
   lsu_pkg::addr_t     dp_addr;
   lsu_pkg::mem_size_e dp_size;
   int                 waits;

   tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

   lsu_top dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .wb      (wb),
      .stall   (stall),
      .hrdatad (hrdatad),
      .hreadyd (hreadyd),
      .haddrd  (haddrd),
      .hsized  (hsized),
      .hwrited (hwrited),
      .htransd (htransd),
      .hwdatad (hwdatad)
   );

   lsu_checker u_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .htransd     (htransd),
      .hreadyd     (hreadyd),
      .haddrd      (haddrd),
      .hsized      (hsized),
      .hwrited     (hwrited),
      .hwdatad     (hwdatad),
      .wb          (wb),
      .stall       (stall),
      .exp_data    (exp_data),
      .test_idx    (cur_idx),
      .done_count  (done_count),
      .error_count (error_count)
   );

   task automatic add_store(lsu_pkg::mem_size_e size, logic [31:0] addr, logic [31:0] wdata,
                            logic [4:0] rs1, logic [4:0] rs2, int w, logic stress);
      tbl[n_entries].req    = '{load: 1'b0, store: 1'b1, size: size, is_unsigned: 1'b0,
                                addr: addr, wdata: wdata, rd: 5'd0, rs1: rs1, rs2: rs2};
      // Stress entries get up to 3 extra wait states
      tbl[n_entries].waits  = stress ? w + int'($urandom % 4) : w;
      tbl[n_entries].exp    = '0;
      n_entries++;
   endtask

   task automatic add_load(lsu_pkg::mem_size_e size, logic uns, logic [31:0] addr,
                           logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2, int w,
                           logic stress, logic [31:0] exp);
      tbl[n_entries].req    = '{load: 1'b1, store: 1'b0, size: size, is_unsigned: uns,
                                addr: addr, wdata: '0, rd: rd, rs1: rs1, rs2: rs2};
      tbl[n_entries].waits  = stress ? w + int'($urandom % 4) : w;
      tbl[n_entries].exp    = exp;
      n_entries++;
   endtask

   // ========================================
   // AHB slave memory model
   // ========================================

   always @(negedge clk) begin
      acc_s   = rst_n && htransd && hreadyd;
      addr_s  = haddrd;
      size_s  = hsized;
      write_s = hwrited;
      wdata_s = hwdatad;
      idx_s   = cur_idx;
   end

   always @(posedge clk) begin
      logic [3:0] be;
      #2;
      if (!rst_n) begin
         dp_valid = 1'b0;
         waits    = 0;
      end else if (hreadyd) begin
         // Store data lands at the end of its data phase
         if (dp_valid && dp_write) begin
            be = (dp_size == SZ_B) ? (4'b0001 << dp_addr[1:0]) :
                 (dp_size == SZ_H) ? (dp_addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;
            for (int b = 0; b < 4; b++) begin
               if (be[b]) begin
                  mem[dp_addr[5:2]][8*b +: 8] = wdata_s[8*b +: 8];
               end
            end
         end
         dp_valid = acc_s;
         dp_write = write_s;
         dp_addr  = addr_s;
         dp_size  = size_s;
         waits    = acc_s ? tbl[idx_s].waits : 0;
      end else begin
         waits--;
      end
      hreadyd = !dp_valid || waits == 0;
      hrdatad = (dp_valid && !dp_write) ? mem[dp_addr[5:2]] : '0;
   end

   // ========================================
   // Stimulus
   // ========================================

   initial begin
      req       = '0;
      hreadyd   = 1'b1;
      hrdatad   = '0;
      exp_data  = '0;
      cur_idx   = 0;
      n_entries = 0;
      dp_valid  = 1'b0;
      void'($urandom(32'hcc20));
      // Fill depends on every address bit
      for (int i = 0; i < 16; i++) begin
         mem[i] = 32'h5a000000 ^ (i * 32'h01030507);
      end

      add_store(SZ_W, 32'h00, 32'h12345678, 5'd0, 5'd0, 0, 1'b0);
      add_load (SZ_W, 1'b0, 32'h00, 5'd5, 5'd1, 5'd2, 0, 1'b0, 32'h12345678);
      // Byte and halfword lanes, merged word read back
      add_store(SZ_B, 32'h04, 32'hffffff91, 5'd0, 5'd0, 0, 1'b0);
      add_store(SZ_B, 32'h05, 32'h0000aba2, 5'd0, 5'd0, 0, 1'b0);
      add_store(SZ_B, 32'h06, 32'h000000b3, 5'd0, 5'd0, 0, 1'b0);
      add_store(SZ_B, 32'h07, 32'h12345684, 5'd0, 5'd0, 0, 1'b0);
      add_load (SZ_W, 1'b0, 32'h04, 5'd6, 5'd0, 5'd0, 0, 1'b0, 32'h84b3a291);
      add_store(SZ_H, 32'h08, 32'hffff9abc, 5'd0, 5'd0, 0, 1'b0);
      add_store(SZ_H, 32'h0a, 32'h0000f00d, 5'd0, 5'd0, 0, 1'b0);
      add_load (SZ_W, 1'b0, 32'h08, 5'd7, 5'd0, 5'd0, 0, 1'b0, 32'hf00d9abc);
      // Extension at every offset
      add_load (SZ_B, 1'b1, 32'h04, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'h00000091);
      add_load (SZ_B, 1'b0, 32'h04, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'hffffff91);
      add_load (SZ_B, 1'b0, 32'h05, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'hffffffa2);
      add_load (SZ_B, 1'b1, 32'h05, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'h000000a2);
      add_load (SZ_B, 1'b1, 32'h06, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'h000000b3);
      add_load (SZ_B, 1'b0, 32'h06, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'hffffffb3);
      add_load (SZ_B, 1'b0, 32'h07, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'hffffff84);
      add_load (SZ_B, 1'b1, 32'h07, 5'd8, 5'd0, 5'd0, 0, 1'b0, 32'h00000084);
      add_load (SZ_H, 1'b0, 32'h08, 5'd9, 5'd0, 5'd0, 0, 1'b0, 32'hffff9abc);
      add_load (SZ_H, 1'b1, 32'h08, 5'd9, 5'd0, 5'd0, 0, 1'b0, 32'h00009abc);
      add_load (SZ_H, 1'b0, 32'h0a, 5'd9, 5'd0, 5'd0, 0, 1'b0, 32'hfffff00d);
      add_load (SZ_H, 1'b1, 32'h0a, 5'd9, 5'd0, 5'd0, 0, 1'b0, 32'h0000f00d);
      // Wait states
      add_store(SZ_W, 32'h0c, 32'hdeadbeef, 5'd0, 5'd0, 3, 1'b0);
      add_load (SZ_W, 1'b0, 32'h0c, 5'd9, 5'd0, 5'd0, 4, 1'b0, 32'hdeadbeef);
      // Independent load then store, back to back
      add_load (SZ_W, 1'b0, 32'h00, 5'd10, 5'd0, 5'd0, 0, 1'b0, 32'h12345678);
      add_store(SZ_W, 32'h10, 32'hcafef00d, 5'd0, 5'd0, 0, 1'b0);
      add_load (SZ_W, 1'b0, 32'h10, 5'd11, 5'd1, 5'd2, 0, 1'b0, 32'hcafef00d);
      // Load-use interlock on rs1, then on rs2
      add_load (SZ_W, 1'b0, 32'h00, 5'd12, 5'd0, 5'd0, 2, 1'b0, 32'h12345678);
      add_store(SZ_W, 32'h14, 32'h0badf00d, 5'd12, 5'd0, 0, 1'b0);
      add_load (SZ_W, 1'b0, 32'h14, 5'd13, 5'd0, 5'd12, 0, 1'b0, 32'h0badf00d);
      add_load (SZ_W, 1'b0, 32'h04, 5'd14, 5'd0, 5'd0, 1, 1'b0, 32'h84b3a291);
      add_load (SZ_B, 1'b0, 32'h07, 5'd15, 5'd3, 5'd14, 0, 1'b0, 32'hffffff84);
      // Stress with random extra wait states
      add_store(SZ_W, 32'h18, 32'h13579bdf, 5'd0, 5'd0, 1, 1'b1);
      add_load (SZ_W, 1'b0, 32'h18, 5'd16, 5'd0, 5'd0, 0, 1'b1, 32'h13579bdf);
      add_load (SZ_H, 1'b1, 32'h1a, 5'd17, 5'd0, 5'd0, 2, 1'b1, 32'h00001357);

      wait (rst_n);
      @(posedge clk);
      #2;
      for (int i = 0; i < NUM; i++) begin
         req      = tbl[i].req;
         exp_data = tbl[i].exp;
         cur_idx  = i;
         // Held until the address phase is taken
         do begin
            @(posedge clk);
         end while (!acc_s);
         #2;
      end
      req = '0;
      wait (done_count == NUM);
      @(posedge clk);
      $display("Tests run %0d, errors %0d", done_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (NUM * 40) @(posedge clk);
      $display("Timeout: the tests did not complete in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== bench/lsu_checker.sv ====
/* Monitor for the load/store unit testbench.
   Samples on the falling edge, predicts store lanes and compares write-backs. */

`timescale 1ns/1ns

module lsu_checker (
   input  logic               clk,
   input  logic               rst_n,
   input  lsu_pkg::lsu_req_t  req,
   input  logic               htransd,
   input  logic               hreadyd,
   input  lsu_pkg::addr_t     haddrd,
   input  lsu_pkg::mem_size_e hsized,
   input  logic               hwrited,
   input  lsu_pkg::data_t     hwdatad,
   input  lsu_pkg::wb_t       wb,
   input  logic               stall,
   input  lsu_pkg::data_t     exp_data,
   input  int                 test_idx,
   output int                 done_count,
   output int                 error_count
);

   // Record of the access in its data phase
   logic             dv;
   logic             d_load;
   lsu_pkg::reg_idx_t d_rd;
   lsu_pkg::data_t   d_hw;
   lsu_pkg::data_t   d_exp;
   int               d_idx;
   int               d_bad;
   logic             p_wait;
   lsu_pkg::addr_t   p_addr;
   logic             strobe;
   logic             exp_trans;
   logic             exp_stall;

   // Low byte or halfword shifted to its store lane
   function automatic lsu_pkg::data_t place_lanes(lsu_pkg::lsu_req_t r);
      lsu_pkg::data_t w;
      w = r.wdata;
      if (r.size == lsu_pkg::SIZE_BYTE) begin
         return {24'b0, w[7:0]} << (8 * r.addr[1:0]);
      end else if (r.size == lsu_pkg::SIZE_HALF) begin
         return r.addr[1] ? {w[15:0], 16'b0} : {16'b0, w[15:0]};
      end
      return w;
   endfunction

   task automatic value_error(string name, int idx, lsu_pkg::data_t got,
                              lsu_pkg::data_t exp);
      $display("FAILED %s in test %0d: got %h expected %h", name, idx, got, exp);
      error_count++;
      d_bad++;
   endtask

   task automatic plain_error(string msg, int idx);
      $display("Error in test %0d: %s", idx, msg);
      error_count++;
      d_bad++;
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         dv          = 1'b0;
         p_wait      = 1'b0;
         d_bad       = 0;
         done_count  = 0;
         error_count = 0;
      end else begin
         strobe = req.load | req.store;
         // Held back while a pending load writes a source register
         exp_trans = strobe &&
                     !(dv && d_load && (req.rs1 == d_rd || req.rs2 == d_rd));
         exp_stall = strobe && !(exp_trans && hreadyd);
         if (p_wait && (!htransd || haddrd != p_addr)) begin
            plain_error("address phase changed during a wait state", test_idx);
         end
         if (haddrd != req.addr) begin
            value_error("haddrd", test_idx, haddrd, req.addr);
         end
         if (hsized != req.size) begin
            value_error("hsized", test_idx, {29'b0, hsized}, {29'b0, req.size});
         end
         if (hwrited != req.store) begin
            value_error("hwrited", test_idx, {31'b0, hwrited}, {31'b0, req.store});
         end
         if (htransd != exp_trans) begin
            value_error("htransd", test_idx, {31'b0, htransd}, {31'b0, exp_trans});
         end
         if (stall != exp_stall) begin
            value_error("stall", test_idx, {31'b0, stall}, {31'b0, exp_stall});
         end
         if (dv && !d_load && hwdatad != d_hw) begin
            value_error("hwdatad", d_idx, hwdatad, d_hw);
         end

         // Data phase ends
         if (dv && hreadyd) begin
            if (d_load) begin
               if (!wb.valid) begin
                  plain_error("no write-back at the end of the load", d_idx);
               end
               if (wb.rd != d_rd) begin
                  value_error("wb.rd", d_idx, {27'b0, wb.rd}, {27'b0, d_rd});
               end
               if (wb.data != d_exp) begin
                  value_error("wb.data", d_idx, wb.data, d_exp);
               end
            end else if (wb.valid) begin
               plain_error("write-back raised for a store", d_idx);
            end
            if (d_bad == 0) begin
               $display("test %0d passed", d_idx);
            end else begin
               $display("test %0d failed with %0d errors", d_idx, d_bad);
            end
            done_count++;
            dv = 1'b0;
         end else if (wb.valid) begin
            plain_error("write-back outside the end of a load", test_idx);
         end

         p_wait = htransd && !hreadyd;
         p_addr = haddrd;

         // New access enters its data phase
         if (htransd && hreadyd) begin
            dv     = 1'b1;
            d_load = req.load;
            d_rd   = req.rd;
            d_hw   = place_lanes(req);
            d_exp  = exp_data;
            d_idx  = test_idx;
            d_bad  = 0;
         end
      end
   end

endmodule

// ==== bench/tb_clock_gen.sv ====
/* Testbench clock and reset source.
   40 ns clock, reset held low for the first 5 rising edges. */

`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      #2 rst_n = 1'b1;
   end

endmodule

// ==== hw/lsu_top.sv ====
/* Load/store unit top level with an AHB-Lite data master port.
   Takes one request at a time from the execute stage and returns load write-backs. */

`timescale 1ns/1ns

module lsu_top (
   input  logic               clk,
   input  logic               rst_n,

   // Execute stage side
   input  lsu_pkg::lsu_req_t  req,
   output lsu_pkg::wb_t       wb,
   output logic               stall,

   // AHB-Lite data port
   input  lsu_pkg::data_t     hrdatad,
   input  logic               hreadyd,
   output lsu_pkg::addr_t     haddrd,
   output lsu_pkg::mem_size_e hsized,
   output logic               hwrited,
   output logic               htransd,
   output lsu_pkg::data_t     hwdatad
);

   logic             accept;
   logic             data_ok;
   lsu_pkg::dphase_t dphase;

   // ======================================
   // Address phase straight from the request
   // ======================================

   assign haddrd  = req.addr;
   assign hsized  = req.size;
   assign hwrited = req.store;

   // ======================================
   // Blocks
   // ======================================

   lsu_phase_ctrl u_phase_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .hreadyd   (hreadyd),
      .htransd   (htransd),
      .accept    (accept),
      .interlock (),
      .stall     (stall),
      .dphase    (dphase),
      .data_ok   (data_ok)
   );

   lsu_store_align u_store_align (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .accept  (accept),
      .hwdatad (hwdatad)
   );

   // Write-back is valid in the last cycle of a load data phase
   lsu_load_extract u_load_extract (
      .dphase  (dphase),
      .data_ok (data_ok),
      .hrdatad (hrdatad),
      .wb      (wb)
   );

endmodule

// ==== hw/lsu/lsu_load_extract.sv ====
/* Load data lane selection with sign or zero extension.
   Purely combinational from hrdatad into the write-back record. */

`timescale 1ns/1ns

module lsu_load_extract (
   input  lsu_pkg::dphase_t dphase,
   input  logic             data_ok,
   input  lsu_pkg::data_t   hrdatad,
   output lsu_pkg::wb_t     wb
);

   logic [7:0]     byte_lane;
   logic [15:0]    half_lane;
   lsu_pkg::data_t load_data;

   // Byte lane from the captured offset
   always_comb begin
      case (dphase.off)
         2'b00: begin
            byte_lane = hrdatad[7:0];
         end
         2'b01: begin
            byte_lane = hrdatad[15:8];
         end
         2'b10: begin
            byte_lane = hrdatad[23:16];
         end
         default: begin
            byte_lane = hrdatad[31:24];
         end
      endcase
   end

   assign half_lane = dphase.off[1] ? hrdatad[31:16] : hrdatad[15:0];

   // Extension by size and signedness
   always_comb begin
      case (dphase.size)
         lsu_pkg::SIZE_BYTE: begin
            load_data = dphase.is_unsigned ? {24'b0, byte_lane}
                                           : {{24{byte_lane[7]}}, byte_lane};
         end
         lsu_pkg::SIZE_HALF: begin
            load_data = dphase.is_unsigned ? {16'b0, half_lane}
                                           : {{16{half_lane[15]}}, half_lane};
         end
         default: begin
            load_data = hrdatad;
         end
      endcase
   end

   assign wb.valid = data_ok;
   assign wb.rd    = dphase.rd;
   assign wb.data  = load_data;

endmodule

// ==== hw/lsu/lsu_store_align.sv ====
/* Store data lane placement for the AHB write data bus.
   Data is registered at address acceptance to line up with the data phase. */

`timescale 1ns/1ns

module lsu_store_align (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::lsu_req_t req,
   input  logic              accept,
   output lsu_pkg::data_t    hwdatad
);

   lsu_pkg::lane_off_t off;
   lsu_pkg::data_t     wdata_lane;

   assign off = req.addr[1:0];

   // ======================================
   // Lane placement
   // ======================================

   always_comb begin
      wdata_lane = '0;
      case (req.size)
         lsu_pkg::SIZE_BYTE: begin
            case (off)
               2'b00: begin
                  wdata_lane = {24'b0, req.wdata[7:0]};
               end
               2'b01: begin
                  wdata_lane = {16'b0, req.wdata[7:0], 8'b0};
               end
               2'b10: begin
                  wdata_lane = {8'b0, req.wdata[7:0], 16'b0};
               end
               default: begin
                  wdata_lane = {req.wdata[7:0], 24'b0};
               end
            endcase
         end
         lsu_pkg::SIZE_HALF: begin
            // Only bit 1 picks the halfword lane
            if (off[1]) begin
               wdata_lane = {req.wdata[15:0], 16'b0};
            end else begin
               wdata_lane = {16'b0, req.wdata[15:0]};
            end
         end
         default: begin
            wdata_lane = req.wdata;
         end
      endcase
   end

   // ======================================
   // Data phase register
   // ======================================

   // Holds through wait states since accept stays low
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdatad <= '0;
      end else if (accept) begin
         hwdatad <= wdata_lane;
      end
   end

endmodule

// ==== hw/lsu/lsu_phase_ctrl.sv ====
/* AHB address/data phase sequencing for the load/store unit.
   Tracks the pending load and raises the load-use interlock and stall. */

`timescale 1ns/1ns

module lsu_phase_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::lsu_req_t req,
   input  logic              hreadyd,
   output logic              htransd,
   output logic              accept,
   output logic              interlock,
   output logic              stall,
   output lsu_pkg::dphase_t  dphase,
   output logic              data_ok
);

   lsu_pkg::phase_state_e state;
   lsu_pkg::phase_state_e state_nxt;
   logic                  strobe;
   logic                  load_pending;
   logic                  rs_match;

   // ======================================
   // Address phase request
   // ======================================

   assign strobe = req.load | req.store;

   // A load sits in its data phase until hreadyd is seen high
   assign load_pending = (state == lsu_pkg::PH_LOAD) & dphase.is_load;

   // Either source register reads the destination of the pending load
   assign rs_match = (dphase.rd == req.rs1) | (dphase.rd == req.rs2);

   // Held through the final cycle so the write-back lands first
   assign interlock = load_pending & rs_match;

   assign htransd = strobe & ~interlock;
   assign accept  = htransd & hreadyd;

   // Execute stage must hold the request
   assign stall = strobe & ~accept;

   // Load data phase ends this cycle
   assign data_ok = (state == lsu_pkg::PH_LOAD) & hreadyd;

   // ======================================
   // Data phase state machine
   // ======================================

   always_comb begin
      state_nxt = state;
      if (hreadyd) begin
         if (accept) begin
            // Next data phase starts right behind the current one
            if (req.load) begin
               state_nxt = lsu_pkg::PH_LOAD;
            end else begin
               state_nxt = lsu_pkg::PH_STORE;
            end
         end else begin
            state_nxt = lsu_pkg::PH_IDLE;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= lsu_pkg::PH_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ======================================
   // Data phase record
   // ======================================

   // Size, sign and lane captured with the address
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dphase.is_load     <= 1'b0;
         dphase.size        <= lsu_pkg::SIZE_WORD;
         dphase.is_unsigned <= 1'b0;
         dphase.off         <= '0;
         dphase.rd          <= '0;
      end else if (accept) begin
         dphase.is_load     <= req.load;
         dphase.size        <= req.size;
         dphase.is_unsigned <= req.is_unsigned;
         dphase.off         <= req.addr[1:0];
         dphase.rd          <= req.rd;
      end
   end

endmodule

// ==== common/lsu_pkg.sv ====
/* Shared types for the load/store unit and its testbench.
   Widths follow RV32 and the AHB-Lite data port. */

package lsu_pkg;

   // ======================================
   // Basic widths
   // ======================================

   // One data word on the bus
   typedef logic [31:0] data_t;

   // Byte address
   typedef logic [31:0] addr_t;

   // Register file index
   typedef logic [4:0] reg_idx_t;

   // Byte offset inside a word
   typedef logic [1:0] lane_off_t;

   // ======================================
   // Enumerations
   // ======================================

   // Encodings match AHB hsize
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'b000,
      SIZE_HALF = 3'b001,
      SIZE_WORD = 3'b010
   } mem_size_e;

   // Kind of data phase in progress
   typedef enum logic [1:0] {
      PH_IDLE  = 2'b00,
      PH_LOAD  = 2'b01,
      PH_STORE = 2'b10
   } phase_state_e;

   // ======================================
   // Structures
   // ======================================

   // Request from the execute stage
   typedef struct packed {
      logic      load;
      logic      store;
      mem_size_e size;
      logic      is_unsigned;
      addr_t     addr;
      data_t     wdata;
      reg_idx_t  rd;
      reg_idx_t  rs1;
      reg_idx_t  rs2;
   } lsu_req_t;

   // Captured at address acceptance, used during the data phase
   typedef struct packed {
      logic      is_load;
      mem_size_e size;
      logic      is_unsigned;
      lane_off_t off;
      reg_idx_t  rd;
   } dphase_t;

   // Load write-back to the register file
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      data_t    data;
   } wb_t;

endpackage
